/* flist.f */
+incdir+rtl
rtl/extmem_cfg_pkg.sv
rtl/extmem_err_pkg.sv
rtl/region_table.sv
rtl/store_pair_queue.sv
rtl/store_unit.sv
rtl/backing_mem.sv
rtl/load_unit.sv
rtl/error_monitor.sv
rtl/fabric_extmemory.sv
tests/tb_extmemory.sv

/* rtl/backing_mem.sv */
// ----------------------------------------------------------
// Backing memory, clocked write and combinational read
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "extmem_params.svh"

module backing_mem (
  input  logic                  clk,
  input  logic                  we,
  input  extmem_cfg_pkg::addr_t waddr,
  input  extmem_cfg_pkg::elem_t wdata,
  input  extmem_cfg_pkg::addr_t raddr,
  output extmem_cfg_pkg::elem_t rdata
);

  extmem_cfg_pkg::elem_t mem [`EXTMEM_MEM_DEPTH];

  // Cleared contents at time zero
  initial begin
    for (int i = 0; i < `EXTMEM_MEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr];

endmodule

/* rtl/error_monitor.sv */
// ----------------------------------------------------------
// Error priority encoder and first-error latch
// ----------------------------------------------------------
`timescale 1ns/1ps

module error_monitor (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      err_overlap,
  input  logic                      err_empty_range,
  input  logic                      ld_tag_oob,
  input  logic                      st_tag_oob,
  input  logic                      ld_no_match,
  input  logic                      st_no_match,
  output logic                      error_valid,
  output extmem_err_pkg::err_code_e error_code
);

  logic                      err_detect;
  extmem_err_pkg::err_code_e err_code_next;

  // Configuration faults outrank runtime faults
  always_comb begin
    err_detect    = 1'b1;
    err_code_next = extmem_err_pkg::ERR_NONE;
    if (err_overlap) begin
      err_code_next = extmem_err_pkg::ERR_CFG_OVERLAP;
    end else if (err_empty_range) begin
      err_code_next = extmem_err_pkg::ERR_CFG_EMPTY_RANGE;
    end else if (ld_tag_oob || st_tag_oob) begin
      err_code_next = extmem_err_pkg::ERR_RT_TAG_OOB;
    end else if (ld_no_match || st_no_match) begin
      err_code_next = extmem_err_pkg::ERR_RT_NO_MATCH;
    end else begin
      err_detect = 1'b0;
    end
  end

  // Only the first error is kept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= extmem_err_pkg::ERR_NONE;
    end else if (!error_valid && err_detect) begin
      error_valid <= 1'b1;
      error_code  <= err_code_next;
    end
  end

endmodule

/* rtl/extmem_cfg_pkg.sv */
// ----------------------------------------------------------
// Address, data, tag and region-entry types
// ----------------------------------------------------------
`include "extmem_params.svh"

package extmem_cfg_pkg;

  typedef logic [`EXTMEM_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`EXTMEM_ELEM_WIDTH-1:0] elem_t;
  typedef logic [`EXTMEM_TAG_WIDTH-1:0]  tag_t;

  // Tag sits above the payload
  typedef struct packed {
    tag_t  tag;
    addr_t addr;
  } tagged_addr_t;

  typedef struct packed {
    tag_t  tag;
    elem_t data;
  } tagged_elem_t;

  // One region entry, offset in the low bits
  typedef struct packed {
    logic  valid;
    tag_t  start_tag;
    tag_t  end_tag;
    addr_t offset;
  } region_t;

endpackage

/* rtl/extmem_err_pkg.sv */
// ----------------------------------------------------------
// Error codes reported by the memory port
// ----------------------------------------------------------
package extmem_err_pkg;

  typedef enum logic [15:0] {
    ERR_NONE            = 16'd0,
    // Configuration faults
    ERR_CFG_OVERLAP     = 16'd1,
    ERR_CFG_EMPTY_RANGE = 16'd2,
    // Runtime faults
    ERR_RT_TAG_OOB      = 16'd3,
    ERR_RT_NO_MATCH     = 16'd4
  } err_code_e;

endpackage

/* rtl/extmem_params.svh */
// ----------------------------------------------------------
// Widths, port counts and sizes of the external memory port
// ----------------------------------------------------------
`ifndef EXTMEM_PARAMS_SVH
`define EXTMEM_PARAMS_SVH

// Word address and data word
`define EXTMEM_ADDR_WIDTH 8
`define EXTMEM_ELEM_WIDTH 32

// Tag in the top bits of every request
`define EXTMEM_TAG_WIDTH 2
`define EXTMEM_LD_COUNT 3
`define EXTMEM_ST_COUNT 3

// Store queue and backing memory sizes
`define EXTMEM_LSQ_DEPTH 4
`define EXTMEM_MEM_DEPTH 256

// Region table layout, valid + start tag + end tag + offset per entry
`define EXTMEM_NUM_REGION 4
`define EXTMEM_REGION_BITS 13
`define EXTMEM_CFG_BITS 52

`endif

/* rtl/fabric_extmemory.sv */
// ----------------------------------------------------------
// External memory port top level
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "extmem_params.svh"

module fabric_extmemory (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`EXTMEM_CFG_BITS-1:0]  cfg_data,

  input  logic                         ld_addr_valid,
  output logic                         ld_addr_ready,
  input  extmem_cfg_pkg::tagged_addr_t ld_addr_data,
  input  logic                         st_addr_valid,
  output logic                         st_addr_ready,
  input  extmem_cfg_pkg::tagged_addr_t st_addr_data,
  input  logic                         st_data_valid,
  output logic                         st_data_ready,
  input  extmem_cfg_pkg::tagged_elem_t st_data_data,

  output logic                         ld_data_valid,
  input  logic                         ld_data_ready,
  output extmem_cfg_pkg::tagged_elem_t ld_data_data,
  output logic                         ld_done_valid,
  input  logic                         ld_done_ready,
  output extmem_cfg_pkg::tag_t         ld_done_data,
  output logic                         st_done_valid,
  input  logic                         st_done_ready,
  output extmem_cfg_pkg::tag_t         st_done_data,

  output logic                         error_valid,
  output extmem_err_pkg::err_code_e    error_code
);

  extmem_cfg_pkg::addr_t ld_offset;
  extmem_cfg_pkg::addr_t st_offset;
  logic                  ld_match;
  logic                  st_match;
  logic                  err_overlap;
  logic                  err_empty_range;
  logic                  ld_tag_oob;
  logic                  st_tag_oob;
  logic                  ld_no_match;
  logic                  st_no_match;

  // Memory ports
  logic                  mem_we;
  extmem_cfg_pkg::addr_t mem_waddr;
  extmem_cfg_pkg::elem_t mem_wdata;
  extmem_cfg_pkg::addr_t mem_raddr;
  extmem_cfg_pkg::elem_t mem_rdata;

  region_table i_region_table (
    .cfg_data        (cfg_data),
    .ld_tag          (ld_addr_data.tag),
    .st_tag          (st_addr_data.tag),
    .ld_offset       (ld_offset),
    .ld_match        (ld_match),
    .st_offset       (st_offset),
    .st_match        (st_match),
    .err_overlap     (err_overlap),
    .err_empty_range (err_empty_range)
  );

  load_unit i_load_unit (
    .ld_addr_valid (ld_addr_valid),
    .ld_addr_ready (ld_addr_ready),
    .ld_addr_data  (ld_addr_data),
    .ld_data_valid (ld_data_valid),
    .ld_data_ready (ld_data_ready),
    .ld_data_data  (ld_data_data),
    .ld_done_valid (ld_done_valid),
    .ld_done_ready (ld_done_ready),
    .ld_done_data  (ld_done_data),
    .ld_offset     (ld_offset),
    .ld_match      (ld_match),
    .mem_raddr     (mem_raddr),
    .mem_rdata     (mem_rdata),
    .err_tag_oob   (ld_tag_oob),
    .err_no_match  (ld_no_match)
  );

  store_unit i_store_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .st_addr_valid (st_addr_valid),
    .st_addr_ready (st_addr_ready),
    .st_addr_data  (st_addr_data),
    .st_data_valid (st_data_valid),
    .st_data_ready (st_data_ready),
    .st_data_data  (st_data_data),
    .st_offset     (st_offset),
    .st_match      (st_match),
    .st_done_valid (st_done_valid),
    .st_done_ready (st_done_ready),
    .st_done_data  (st_done_data),
    .mem_we        (mem_we),
    .mem_waddr     (mem_waddr),
    .mem_wdata     (mem_wdata),
    .err_tag_oob   (st_tag_oob),
    .err_no_match  (st_no_match)
  );

  backing_mem i_backing_mem (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

  error_monitor i_error_monitor (
    .clk             (clk),
    .rst_n           (rst_n),
    .err_overlap     (err_overlap),
    .err_empty_range (err_empty_range),
    .ld_tag_oob      (ld_tag_oob),
    .st_tag_oob      (st_tag_oob),
    .ld_no_match     (ld_no_match),
    .st_no_match     (st_no_match),
    .error_valid     (error_valid),
    .error_code      (error_code)
  );

endmodule

/* rtl/load_unit.sv */
// ----------------------------------------------------------
// Load translation and aligned data/done handshake
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "extmem_params.svh"

module load_unit (
  input  logic                         ld_addr_valid,
  output logic                         ld_addr_ready,
  input  extmem_cfg_pkg::tagged_addr_t ld_addr_data,
  output logic                         ld_data_valid,
  input  logic                         ld_data_ready,
  output extmem_cfg_pkg::tagged_elem_t ld_data_data,
  output logic                         ld_done_valid,
  input  logic                         ld_done_ready,
  output extmem_cfg_pkg::tag_t         ld_done_data,
  input  extmem_cfg_pkg::addr_t        ld_offset,
  input  logic                         ld_match,
  output extmem_cfg_pkg::addr_t        mem_raddr,
  input  extmem_cfg_pkg::elem_t        mem_rdata,
  output logic                         err_tag_oob,
  output logic                         err_no_match
);

  logic in_range;

  assign in_range = int'(ld_addr_data.tag) < `EXTMEM_LD_COUNT;

  // Data and done leave together, so each waits on the other's ready
  assign ld_addr_ready = in_range && ld_data_ready && ld_done_ready;
  assign ld_data_valid = ld_addr_valid && in_range && ld_done_ready;
  assign ld_done_valid = ld_addr_valid && in_range && ld_data_ready;

  assign mem_raddr    = ld_addr_data.addr + ld_offset;
  assign ld_data_data = '{tag: ld_addr_data.tag, data: mem_rdata};
  assign ld_done_data = ld_addr_data.tag;

  assign err_tag_oob  = ld_addr_valid && !in_range;
  assign err_no_match = ld_addr_valid && in_range && !ld_match;

endmodule

/* rtl/region_table.sv */
// ----------------------------------------------------------
// Region table decode, configuration checks and tag lookup
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "extmem_params.svh"

module region_table (
  input  logic [`EXTMEM_CFG_BITS-1:0] cfg_data,
  input  extmem_cfg_pkg::tag_t        ld_tag,
  input  extmem_cfg_pkg::tag_t        st_tag,
  output extmem_cfg_pkg::addr_t       ld_offset,
  output logic                        ld_match,
  output extmem_cfg_pkg::addr_t       st_offset,
  output logic                        st_match,
  output logic                        err_overlap,
  output logic                        err_empty_range
);

  localparam int NUM_REGION = `EXTMEM_NUM_REGION;

  // Entry 0 occupies the low bits of the configuration word
  extmem_cfg_pkg::region_t [NUM_REGION-1:0] regions;
  logic [NUM_REGION-1:0]                    live;

  assign regions = cfg_data;

  // Highest-numbered matching region wins
  function automatic logic [`EXTMEM_ADDR_WIDTH:0] lookup(
    input extmem_cfg_pkg::region_t [NUM_REGION-1:0] tbl,
    input extmem_cfg_pkg::tag_t                     tag
  );
    logic [`EXTMEM_ADDR_WIDTH:0] result;
    result = '0;
    for (int i = 0; i < NUM_REGION; i++) begin
      if (tbl[i].valid && tag >= tbl[i].start_tag && tag <= tbl[i].end_tag) begin
        result = {1'b1, tbl[i].offset};
      end
    end
    return result;
  endfunction

  assign {ld_match, ld_offset} = lookup(regions, ld_tag);
  assign {st_match, st_offset} = lookup(regions, st_tag);

  // ----------------------------------------------------------
  // Configuration checks
  // ----------------------------------------------------------
  // An empty range covers no tags, so it never overlaps another region
  always_comb begin
    for (int i = 0; i < NUM_REGION; i++) begin
      live[i] = regions[i].valid && (regions[i].start_tag <= regions[i].end_tag);
    end
  end

  always_comb begin
    err_overlap     = 1'b0;
    err_empty_range = 1'b0;
    for (int i = 0; i < NUM_REGION; i++) begin
      if (regions[i].valid && !live[i]) begin
        err_empty_range = 1'b1;
      end
      for (int j = i + 1; j < NUM_REGION; j++) begin
        if (live[i] && live[j] &&
            regions[i].start_tag <= regions[j].end_tag &&
            regions[j].start_tag <= regions[i].end_tag) begin
          err_overlap = 1'b1;
        end
      end
    end
  end

endmodule

/* rtl/store_pair_queue.sv */
// ----------------------------------------------------------
// Address and data queues for the stores of one tag
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "extmem_params.svh"

module store_pair_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  addr_push,
  input  extmem_cfg_pkg::addr_t addr_in,
  input  logic                  data_push,
  input  extmem_cfg_pkg::elem_t data_in,
  input  logic                  pop,
  output logic                  addr_full,
  output logic                  data_full,
  output logic                  pair_ready,
  output extmem_cfg_pkg::addr_t head_addr,
  output extmem_cfg_pkg::elem_t head_data
);

  localparam int DEPTH = `EXTMEM_LSQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  extmem_cfg_pkg::addr_t addr_mem [DEPTH];
  extmem_cfg_pkg::elem_t data_mem [DEPTH];

  logic [PTR_W-1:0] addr_wr_ptr;
  logic [PTR_W-1:0] addr_rd_ptr;
  logic [PTR_W-1:0] data_wr_ptr;
  logic [PTR_W-1:0] data_rd_ptr;
  logic [PTR_W:0]   addr_count;
  logic [PTR_W:0]   data_count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign addr_full  = (addr_count == (PTR_W+1)'(DEPTH));
  assign data_full  = (data_count == (PTR_W+1)'(DEPTH));
  assign pair_ready = (addr_count != '0) && (data_count != '0);
  assign head_addr  = addr_mem[addr_rd_ptr];
  assign head_data  = data_mem[data_rd_ptr];

  always_ff @(posedge clk) begin
    if (addr_push) begin
      addr_mem[addr_wr_ptr] <= addr_in;
    end
    if (data_push) begin
      data_mem[data_wr_ptr] <= data_in;
    end
  end

  // Pop drops both heads at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wr_ptr <= '0;
      addr_rd_ptr <= '0;
      data_wr_ptr <= '0;
      data_rd_ptr <= '0;
      addr_count  <= '0;
      data_count  <= '0;
    end else begin
      if (addr_push) begin
        addr_wr_ptr <= next_ptr(addr_wr_ptr);
      end
      if (data_push) begin
        data_wr_ptr <= next_ptr(data_wr_ptr);
      end
      if (pop) begin
        addr_rd_ptr <= next_ptr(addr_rd_ptr);
        data_rd_ptr <= next_ptr(data_rd_ptr);
      end
      addr_count <= addr_count + (PTR_W+1)'(addr_push) - (PTR_W+1)'(pop);
      data_count <= data_count + (PTR_W+1)'(data_push) - (PTR_W+1)'(pop);
    end
  end

  // Routing in the store unit must respect the full flags
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(addr_push && addr_full) && !(data_push && data_full));

  // Store done may only retire a complete pair
  a_pop_pair: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> pair_ready);

endmodule

/* rtl/store_unit.sv */
// ----------------------------------------------------------
// Store routing to per-tag queues, pair pick and memory write
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "extmem_params.svh"

module store_unit (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         st_addr_valid,
  output logic                         st_addr_ready,
  input  extmem_cfg_pkg::tagged_addr_t st_addr_data,
  input  logic                         st_data_valid,
  output logic                         st_data_ready,
  input  extmem_cfg_pkg::tagged_elem_t st_data_data,
  input  extmem_cfg_pkg::addr_t        st_offset,
  input  logic                         st_match,
  output logic                         st_done_valid,
  input  logic                         st_done_ready,
  output extmem_cfg_pkg::tag_t         st_done_data,
  output logic                         mem_we,
  output extmem_cfg_pkg::addr_t        mem_waddr,
  output extmem_cfg_pkg::elem_t        mem_wdata,
  output logic                         err_tag_oob,
  output logic                         err_no_match
);

  localparam int ST_COUNT = `EXTMEM_ST_COUNT;

  logic                  addr_in_range;
  logic                  data_in_range;
  extmem_cfg_pkg::addr_t st_phys;

  logic [ST_COUNT-1:0]   addr_push;
  logic [ST_COUNT-1:0]   data_push;
  logic [ST_COUNT-1:0]   pop;
  logic [ST_COUNT-1:0]   addr_full;
  logic [ST_COUNT-1:0]   data_full;
  logic [ST_COUNT-1:0]   pair_ready;
  extmem_cfg_pkg::addr_t head_addr [ST_COUNT];
  extmem_cfg_pkg::elem_t head_data [ST_COUNT];

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------
  assign addr_in_range = int'(st_addr_data.tag) < ST_COUNT;
  assign data_in_range = int'(st_data_data.tag) < ST_COUNT;

  // Wraps modulo the memory size
  assign st_phys = st_addr_data.addr + st_offset;

  assign st_addr_ready = addr_in_range && !addr_full[st_addr_data.tag];
  assign st_data_ready = data_in_range && !data_full[st_data_data.tag];

  for (genvar g = 0; g < ST_COUNT; g++) begin : g_queue
    assign addr_push[g] = st_addr_valid && st_addr_ready && (int'(st_addr_data.tag) == g);
    assign data_push[g] = st_data_valid && st_data_ready && (int'(st_data_data.tag) == g);
    assign pop[g]       = mem_we && (int'(st_done_data) == g);

    store_pair_queue i_store_pair_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr_push  (addr_push[g]),
      .addr_in    (st_phys),
      .data_push  (data_push[g]),
      .data_in    (st_data_data.data),
      .pop        (pop[g]),
      .addr_full  (addr_full[g]),
      .data_full  (data_full[g]),
      .pair_ready (pair_ready[g]),
      .head_addr  (head_addr[g]),
      .head_data  (head_data[g])
    );
  end

  // ----------------------------------------------------------
  // Completion side
  // ----------------------------------------------------------
  // Scan downward so the lowest ready tag is left selected
  always_comb begin
    st_done_valid = 1'b0;
    st_done_data  = '0;
    for (int i = ST_COUNT - 1; i >= 0; i--) begin
      if (pair_ready[i]) begin
        st_done_valid = 1'b1;
        st_done_data  = extmem_cfg_pkg::tag_t'(i);
      end
    end
  end

  assign mem_we    = st_done_valid && st_done_ready;
  assign mem_waddr = head_addr[st_done_data];
  assign mem_wdata = head_data[st_done_data];

  assign err_tag_oob  = (st_addr_valid && !addr_in_range) || (st_data_valid && !data_in_range);
  assign err_no_match = st_addr_valid && addr_in_range && !st_match;

endmodule

/* tests/tb_extmemory.sv */
// ----------------------------------------------------------
// Testbench for the external memory port, directed tests
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "extmem_params.svh"

module tb_extmemory;

  localparam int TIMEOUT = 100;

  logic                         clk;
  logic                         rst_n;
  logic [`EXTMEM_CFG_BITS-1:0]  cfg_data;
  logic                         ld_addr_valid;
  logic                         ld_addr_ready;
  extmem_cfg_pkg::tagged_addr_t ld_addr_data;
  logic                         st_addr_valid;
  logic                         st_addr_ready;
  extmem_cfg_pkg::tagged_addr_t st_addr_data;
  logic                         st_data_valid;
  logic                         st_data_ready;
  extmem_cfg_pkg::tagged_elem_t st_data_data;
  logic                         ld_data_valid;
  logic                         ld_data_ready;
  extmem_cfg_pkg::tagged_elem_t ld_data_data;
  logic                         ld_done_valid;
  logic                         ld_done_ready;
  extmem_cfg_pkg::tag_t         ld_done_data;
  logic                         st_done_valid;
  logic                         st_done_ready;
  extmem_cfg_pkg::tag_t         st_done_data;
  logic                         error_valid;
  extmem_err_pkg::err_code_e    error_code;

  // Expected memory contents and per-tag offsets of the active table
  logic [31:0] model_mem [256];
  logic [7:0]  tag_offset [3];
  string       test_name;

  fabric_extmemory i_fabric_extmemory (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [12:0] region_entry(input logic valid, input logic [1:0] start_tag,
                                               input logic [1:0] end_tag, input logic [7:0] offset);
    return {valid, start_tag, end_tag, offset};
  endfunction

  // Region 0 covers tag 0, region 1 covers tags 1 to 2
  function automatic logic [51:0] default_table();
    return {13'd0, 13'd0, region_entry(1'b1, 2'd1, 2'd2, 8'd64),
            region_entry(1'b1, 2'd0, 2'd0, 8'd16)};
  endfunction

  // Tag 2 left uncovered
  function automatic logic [51:0] table_without_tag2();
    return {13'd0, 13'd0, region_entry(1'b1, 2'd1, 2'd1, 8'd64),
            region_entry(1'b1, 2'd0, 2'd0, 8'd16)};
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else
      report_failure($sformatf("** Error %s: %s expected %0h, actual %0h",
                               test_name, what, expected, actual));
  endtask

  task automatic apply_reset(input logic [51:0] cfg);
    rst_n         = 1'b0;
    cfg_data      = cfg;
    ld_addr_valid = 1'b0;
    ld_addr_data  = '0;
    st_addr_valid = 1'b0;
    st_addr_data  = '0;
    st_data_valid = 1'b0;
    st_data_data  = '0;
    ld_data_ready = 1'b1;
    ld_done_ready = 1'b1;
    st_done_ready = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("error_valid after reset", 0, error_valid);
    check_value("error_code after reset", extmem_err_pkg::ERR_NONE, error_code);
    check_value("st_done_valid after reset", 0, st_done_valid);
    check_value("ld_data_valid after reset", 0, ld_data_valid);
    check_value("ld_done_valid after reset", 0, ld_done_valid);
  endtask

  task automatic send_st_addr(input logic [1:0] tag, input logic [7:0] addr);
    int waited;
    st_addr_valid = 1'b1;
    st_addr_data  = {tag, addr};
    waited = 0;
    @(negedge clk);
    while (!st_addr_ready) begin
      waited++;
      if (waited > TIMEOUT) report_failure("Store address was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    st_addr_valid = 1'b0;
  endtask

  task automatic send_st_data(input logic [1:0] tag, input logic [31:0] data);
    int waited;
    st_data_valid = 1'b1;
    st_data_data  = {tag, data};
    waited = 0;
    @(negedge clk);
    while (!st_data_ready) begin
      waited++;
      if (waited > TIMEOUT) report_failure("Store data was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    st_data_valid = 1'b0;
  endtask

  // Caller holds st_done_ready high
  task automatic take_st_done(input logic [1:0] tag, input logic [7:0] phys,
                              input logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!st_done_valid) begin
      waited++;
      if (waited > TIMEOUT) report_failure("Store done never became valid");
      @(negedge clk);
    end
    check_value("st_done tag", tag, st_done_data);
    @(posedge clk);
    #1;
    model_mem[phys] = data;
  endtask

  task automatic finish_load(input logic [1:0] tag, input logic [7:0] addr);
    int          waited;
    logic [7:0]  phys;
    phys = addr + tag_offset[tag];
    waited = 0;
    @(negedge clk);
    while (!ld_addr_ready) begin
      waited++;
      if (waited > TIMEOUT) report_failure("Load address was never accepted");
      @(negedge clk);
    end
    check_value("ld_data_valid", 1, ld_data_valid);
    check_value("ld_done_valid", 1, ld_done_valid);
    check_value("ld_data", {tag, model_mem[phys]}, ld_data_data);
    check_value("ld_done", tag, ld_done_data);
    @(posedge clk);
    #1;
    ld_addr_valid = 1'b0;
  endtask

  task automatic load_word(input logic [1:0] tag, input logic [7:0] addr);
    ld_addr_valid = 1'b1;
    ld_addr_data  = {tag, addr};
    finish_load(tag, addr);
  endtask

  task automatic wait_error(input extmem_err_pkg::err_code_e expected);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!error_valid) begin
      waited++;
      if (waited > TIMEOUT) report_failure("error_valid never rose");
      @(negedge clk);
    end
    check_value("error_code", expected, error_code);
    @(posedge clk);
    #1;
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_round_trip();
    logic [7:0]  addrs [6];
    logic [1:0]  tags [6];
    logic [31:0] word;
    test_name = "round_trip";
    addrs = '{8'd3, 8'd120, 8'd8, 8'd191, 8'd200, 8'd8};
    tags  = '{2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd2};
    st_done_ready = 1'b1;
    for (int i = 0; i < 6; i++) begin
      word = $urandom();
      send_st_addr(tags[i], addrs[i]);
      send_st_data(tags[i], word);
      take_st_done(tags[i], addrs[i] + tag_offset[tags[i]], word);
    end
    st_done_ready = 1'b0;
    for (int i = 0; i < 6; i++) begin
      load_word(tags[i], addrs[i]);
    end
  endtask

  task automatic test_out_of_order();
    logic [7:0]  pend_addr [3][4];
    logic [31:0] pend_data [3][4];
    int          pend_count [3];
    int          pend_head [3];
    int          pick;
    test_name  = "out_of_order";
    pend_count = '{4, 2, 2};
    pend_head  = '{0, 0, 0};
    for (int t = 0; t < 3; t++) begin
      for (int i = 0; i < pend_count[t]; i++) begin
        pend_addr[t][i] = 8'd32 + 8'(t * 90 + i);
        pend_data[t][i] = $urandom();
        send_st_addr(2'(t), pend_addr[t][i]);
      end
      // Tag 0 queue is full after its fourth address
      if (t == 0) begin
        @(negedge clk);
        check_value("st_addr_ready with tag 0 full", 0, st_addr_ready);
        @(posedge clk);
        #1;
      end
    end
    for (int t = 2; t >= 0; t--) begin
      for (int i = 0; i < pend_count[t]; i++) begin
        send_st_data(2'(t), pend_data[t][i]);
      end
      @(negedge clk);
      check_value("held st_done_valid", 1, st_done_valid);
      check_value("held st_done tag", t, st_done_data);
      @(posedge clk);
      #1;
    end
    st_done_ready = 1'b1;
    for (int n = 0; n < 8; n++) begin
      pick = 0;
      while (pend_head[pick] == pend_count[pick]) pick++;
      take_st_done(2'(pick), pend_addr[pick][pend_head[pick]] + tag_offset[pick],
                   pend_data[pick][pend_head[pick]]);
      pend_head[pick]++;
    end
    st_done_ready = 1'b0;
    for (int t = 0; t < 3; t++) begin
      for (int i = 0; i < pend_count[t]; i++) begin
        load_word(2'(t), pend_addr[t][i]);
      end
    end
  endtask

  task automatic test_load_backpressure();
    test_name     = "load_backpressure";
    ld_data_ready = 1'b0;
    ld_addr_valid = 1'b1;
    ld_addr_data  = {2'd1, 8'd8};
    repeat (3) begin
      @(negedge clk);
      check_value("ld_addr_ready while stalled", 0, ld_addr_ready);
      check_value("ld_done_valid while stalled", 0, ld_done_valid);
    end
    @(posedge clk);
    #1;
    ld_data_ready = 1'b1;
    finish_load(2'd1, 8'd8);
  endtask

  task automatic test_tag_out_of_range();
    test_name = "tag_out_of_range";
    apply_reset(default_table());
    ld_addr_valid = 1'b1;
    ld_addr_data  = {2'd3, 8'd5};
    @(negedge clk);
    check_value("ld_addr_ready for tag 3", 0, ld_addr_ready);
    wait_error(extmem_err_pkg::ERR_RT_TAG_OOB);
    ld_addr_valid = 1'b0;
    // A later no-match store must not replace the first code
    cfg_data = table_without_tag2();
    send_st_addr(2'd2, 8'd10);
    repeat (2) @(posedge clk);
    #1;
    check_value("error_code kept", extmem_err_pkg::ERR_RT_TAG_OOB, error_code);
  endtask

  task automatic test_config_errors();
    test_name = "cfg_overlap";
    apply_reset({26'd0, region_entry(1'b1, 2'd1, 2'd2, 8'd64),
                 region_entry(1'b1, 2'd0, 2'd1, 8'd16)});
    wait_error(extmem_err_pkg::ERR_CFG_OVERLAP);
    test_name = "cfg_empty_range";
    apply_reset({26'd0, region_entry(1'b1, 2'd2, 2'd1, 8'd64),
                 region_entry(1'b1, 2'd0, 2'd0, 8'd16)});
    wait_error(extmem_err_pkg::ERR_CFG_EMPTY_RANGE);
    test_name = "no_match";
    apply_reset(table_without_tag2());
    tag_offset[2] = 8'd0;
    load_word(2'd2, 8'd72);
    wait_error(extmem_err_pkg::ERR_RT_NO_MATCH);
  endtask

  initial begin
    void'($urandom(32'hf430_829c));
    for (int i = 0; i < 256; i++) begin
      model_mem[i] = '0;
    end
    tag_offset = '{8'd16, 8'd64, 8'd64};
    test_name  = "reset";
    apply_reset(default_table());
    test_round_trip();
    test_out_of_order();
    test_load_backpressure();
    test_tag_out_of_range();
    test_config_errors();
    $display("TESTS PASSED");
    $finish;
  end

endmodule
